// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then look for the pass line in the log.
set -u

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module ooo_tb --Mdir "$obj_dir" -f sources.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$obj_dir/Vooo_tb" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qxF "All tests passed!" "$log"; then
  exit 0
fi
echo "pass line not found in $log"
exit 1

// File: source/alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
  input  wire                             clk_in,
  input  wire                             rst_in,
  input  wire                             alu_issue,
  input  wire  isa_pkg::alu_func_t        alu_func,
  input  wire  [isa_pkg::XLEN-1:0]        alu_op_a,
  input  wire  [isa_pkg::XLEN-1:0]        alu_op_b,
  input  wire  ooo_cfg_pkg::rob_ix_t      alu_rob_ix,
  output logic                            alu_wb_valid,
  output ooo_cfg_pkg::rob_ix_t            alu_wb_ix,
  output logic [isa_pkg::XLEN-1:0]        alu_wb_value
);

  logic [isa_pkg::XLEN-1:0] result;
  logic [4:0] shamt;

  assign shamt = alu_op_b[4:0]; // rv32 shifts ignore the upper bits

  always_comb begin
    case (alu_func)
      isa_pkg::ALU_ADD:  result = alu_op_a + alu_op_b;
      isa_pkg::ALU_SUB:  result = alu_op_a - alu_op_b;
      isa_pkg::ALU_AND:  result = alu_op_a & alu_op_b;
      isa_pkg::ALU_OR:   result = alu_op_a | alu_op_b;
      isa_pkg::ALU_XOR:  result = alu_op_a ^ alu_op_b;
      isa_pkg::ALU_SLT:  result = {31'b0, $signed(alu_op_a) < $signed(alu_op_b)};
      isa_pkg::ALU_SLTU: result = {31'b0, alu_op_a < alu_op_b};
      isa_pkg::ALU_SLL:  result = alu_op_a << shamt;
      isa_pkg::ALU_SRL:  result = alu_op_a >> shamt;
      isa_pkg::ALU_SRA:  result = $unsigned($signed(alu_op_a) >>> shamt); // keeps the sign
      default:           result = '0;
    endcase
  end

  // strobe only, the rob never refuses a write
  always_ff @(posedge clk_in) begin
    if (rst_in) alu_wb_valid <= 1'b0;
    else        alu_wb_valid <= alu_issue;
  end

  always_ff @(posedge clk_in) begin
    if (alu_issue) begin
      alu_wb_ix    <= alu_rob_ix;
      alu_wb_value <= result;
    end
  end

endmodule

`default_nettype wire

// File: source/isa_pkg.sv
`default_nettype none

package isa_pkg;

  localparam int XLEN = 32; // integer datapath width

  // major opcodes, instr[6:0]
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;

  // funct3 codes shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101; // srl or sra, picked by funct7
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;
  localparam logic [2:0] F3_LW   = 3'b010; // word load, the only width supported

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000; // sub and sra

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
  } alu_func_t;

  typedef enum logic [1:0] {
    OP_ALU_REG, OP_ALU_IMM, OP_LOAD, OP_ILLEGAL
  } op_class_t;

endpackage

`default_nettype wire

// File: source/issue_decode.sv
`timescale 1ns/1ps
`default_nettype none

module issue_decode (
  input  wire                             clk_in,
  input  wire                             rst_in,
  input  wire                             instr_valid,
  input  wire  [31:0]                     instr,
  output logic                            instr_ready,
  input  wire                             rob_full,
  input  wire                             lb_ready,
  input  wire  ooo_cfg_pkg::rob_ix_t      alloc_ix,
  output logic                            alloc_valid,
  output ooo_cfg_pkg::reg_ix_t            alloc_rd,
  output logic                            alloc_has_dest,
  output logic                            alu_issue,
  output isa_pkg::alu_func_t              alu_func,
  output logic [isa_pkg::XLEN-1:0]        alu_op_a,
  output logic [isa_pkg::XLEN-1:0]        alu_op_b,
  output ooo_cfg_pkg::rob_ix_t            alu_rob_ix,
  output logic                            ld_issue,
  output logic [isa_pkg::XLEN-1:0]        ld_addr,
  output ooo_cfg_pkg::rob_ix_t            ld_rob_ix,
  input  wire                             commit_valid,
  input  wire  ooo_cfg_pkg::reg_ix_t      commit_rd,
  input  wire  [isa_pkg::XLEN-1:0]        commit_value
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] rd_f;
  logic [4:0] rs1_f;
  logic [4:0] rs2_f;
  logic [isa_pkg::XLEN-1:0] imm;
  isa_pkg::op_class_t op_class;
  isa_pkg::alu_func_t func;
  ooo_cfg_pkg::reg_ix_t rd;
  ooo_cfg_pkg::reg_ix_t rs1;
  ooo_cfg_pkg::reg_ix_t rs2;
  logic uses_rs1;
  logic uses_rs2;
  logic is_load;
  logic accept;

  logic [isa_pkg::XLEN-1:0] regs [ooo_cfg_pkg::NUM_REGS];
  logic [ooo_cfg_pkg::NUM_REGS-1:0] busy; // a write to this register is still in flight
  ooo_cfg_pkg::rob_ix_t owner [ooo_cfg_pkg::NUM_REGS]; // newest writer of each register
  ooo_cfg_pkg::rob_ix_t commit_ix; // tracks the rob head, commits are in order

  assign opcode = instr[6:0];
  assign rd_f   = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1_f  = instr[19:15];
  assign rs2_f  = instr[24:20];
  assign funct7 = instr[31:25];
  assign imm    = {{(isa_pkg::XLEN-12){instr[31]}}, instr[31:20]}; // i-type, sign extended
  assign rd     = rd_f[2:0];
  assign rs1    = rs1_f[2:0];
  assign rs2    = rs2_f[2:0];

  always_comb begin
    op_class = isa_pkg::OP_ILLEGAL;
    case (opcode)
      isa_pkg::OPCODE_OP: begin
        if (funct7 == isa_pkg::F7_BASE || (funct7 == isa_pkg::F7_ALT &&
            (funct3 == isa_pkg::F3_ADD || funct3 == isa_pkg::F3_SR)))
          op_class = isa_pkg::OP_ALU_REG;
      end
      isa_pkg::OPCODE_OP_IMM: begin
        // shift immediates carry a funct7 in imm[11:5]
        if ((funct3 != isa_pkg::F3_SLL && funct3 != isa_pkg::F3_SR) ||
            funct7 == isa_pkg::F7_BASE ||
            (funct3 == isa_pkg::F3_SR && funct7 == isa_pkg::F7_ALT))
          op_class = isa_pkg::OP_ALU_IMM;
      end
      isa_pkg::OPCODE_LOAD: if (funct3 == isa_pkg::F3_LW) op_class = isa_pkg::OP_LOAD;
      default: ;
    endcase
    // only x0..x7 exist, so the top two bits of each register field must be clear
    if (rd_f[4:3] != 2'b00 || rs1_f[4:3] != 2'b00 ||
        (op_class == isa_pkg::OP_ALU_REG && rs2_f[4:3] != 2'b00))
      op_class = isa_pkg::OP_ILLEGAL;
  end

  always_comb begin
    case (funct3)
      isa_pkg::F3_ADD: func = (op_class == isa_pkg::OP_ALU_REG && funct7 == isa_pkg::F7_ALT)
                              ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD; // no subi
      isa_pkg::F3_SLL:  func = isa_pkg::ALU_SLL;
      isa_pkg::F3_SLT:  func = isa_pkg::ALU_SLT;
      isa_pkg::F3_SLTU: func = isa_pkg::ALU_SLTU;
      isa_pkg::F3_XOR:  func = isa_pkg::ALU_XOR;
      isa_pkg::F3_SR:   func = (funct7 == isa_pkg::F7_ALT) ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
      isa_pkg::F3_OR:   func = isa_pkg::ALU_OR;
      default:          func = isa_pkg::ALU_AND;
    endcase
    if (op_class == isa_pkg::OP_ILLEGAL) func = isa_pkg::ALU_ADD; // 0 + 0 just to fill the slot
  end

  assign uses_rs1 = op_class != isa_pkg::OP_ILLEGAL;
  assign uses_rs2 = op_class == isa_pkg::OP_ALU_REG;
  assign is_load  = op_class == isa_pkg::OP_LOAD;

  // no forwarding, a busy source waits for its producer to commit
  assign instr_ready = !rob_full && !(uses_rs1 && busy[rs1]) && !(uses_rs2 && busy[rs2]) &&
                       (!is_load || lb_ready);
  assign accept = instr_valid && instr_ready;

  assign alloc_valid    = accept;
  assign alloc_has_dest = op_class != isa_pkg::OP_ILLEGAL;
  assign alloc_rd       = alloc_has_dest ? rd : '0;

  assign alu_issue  = accept && !is_load; // illegal ones ride the alu too
  assign alu_func   = func;
  assign alu_op_a   = uses_rs1 ? regs[rs1] : '0;
  assign alu_op_b   = uses_rs2 ? regs[rs2] : (op_class == isa_pkg::OP_ALU_IMM ? imm : '0);
  assign alu_rob_ix = alloc_ix;

  assign ld_issue  = accept && is_load;
  assign ld_addr   = regs[rs1] + imm;
  assign ld_rob_ix = alloc_ix;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy      <= '0;
      commit_ix <= '0;
      for (int i = 0; i < ooo_cfg_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (commit_valid) begin
        commit_ix <= commit_ix + 1'b1;
        if (commit_rd != '0) regs[commit_rd] <= commit_value; // x0 writes are dropped
        // a newer writer keeps the register busy
        if (owner[commit_rd] == commit_ix) busy[commit_rd] <= 1'b0;
      end
      if (accept && alloc_has_dest && rd != '0) busy[rd] <= 1'b1; // wins over a same-edge clear
    end
  end

  always_ff @(posedge clk_in) begin
    if (accept && alloc_has_dest && rd != '0) owner[rd] <= alloc_ix;
  end

  // every committing writer still finds its register marked busy
  a_commit_busy: assert property (@(posedge clk_in) disable iff (rst_in)
    commit_valid && commit_rd != '0 |-> busy[commit_rd]);

endmodule

`default_nettype wire

// File: source/load_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module load_buffer (
  input  wire                             clk_in,
  input  wire                             rst_in,
  input  wire                             ld_issue,
  input  wire  [isa_pkg::XLEN-1:0]        ld_addr,
  input  wire  ooo_cfg_pkg::rob_ix_t      ld_rob_ix,
  output logic                            lb_ready,
  output logic                            mem_req,
  output logic [isa_pkg::XLEN-1:0]        mem_addr,
  input  wire                             mem_rvalid,
  input  wire  [isa_pkg::XLEN-1:0]        mem_rdata,
  output logic                            ld_wb_valid,
  output ooo_cfg_pkg::rob_ix_t            ld_wb_ix,
  output logic [isa_pkg::XLEN-1:0]        ld_wb_value
);

  logic [ooo_cfg_pkg::LOAD_BUFFER_DEPTH-1:0] occupied;
  logic [isa_pkg::XLEN-1:0] row_addr [ooo_cfg_pkg::LOAD_BUFFER_DEPTH];
  ooo_cfg_pkg::rob_ix_t row_rob_ix [ooo_cfg_pkg::LOAD_BUFFER_DEPTH];
  ooo_cfg_pkg::lb_ix_t row_age [ooo_cfg_pkg::LOAD_BUFFER_DEPTH]; // 0 is the oldest row
  logic out_valid; // a request sits at memory
  ooo_cfg_pkg::lb_ix_t out_row;
  ooo_cfg_pkg::lb_ix_t open_row;
  ooo_cfg_pkg::lb_ix_t oldest_row;
  ooo_cfg_pkg::lb_ix_t occ_count;

  always_comb begin
    open_row = '0;
    for (int i = ooo_cfg_pkg::LOAD_BUFFER_DEPTH - 1; i >= 0; i--) begin
      if (!occupied[i]) open_row = ooo_cfg_pkg::lb_ix_t'(i); // lowest open row wins
    end
    oldest_row = '0;
    for (int i = 0; i < ooo_cfg_pkg::LOAD_BUFFER_DEPTH; i++) begin
      if (occupied[i] && row_age[i] == '0) oldest_row = ooo_cfg_pkg::lb_ix_t'(i);
    end
    occ_count = ooo_cfg_pkg::lb_ix_t'($countones(occupied));
  end

  assign lb_ready = !(&occupied);
  // one request at a time, and it is always the oldest row
  assign mem_req  = !out_valid && (|occupied);
  assign mem_addr = row_addr[oldest_row];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      occupied    <= '0;
      out_valid   <= 1'b0;
      ld_wb_valid <= 1'b0;
    end else begin
      ld_wb_valid <= mem_rvalid; // result goes to the rob one cycle after the response
      if (mem_req) out_valid <= 1'b1;
      if (mem_rvalid) begin
        out_valid         <= 1'b0;
        occupied[out_row] <= 1'b0;
      end
      if (ld_issue) occupied[open_row] <= 1'b1;
    end
  end

  always_ff @(posedge clk_in) begin
    if (mem_req) out_row <= oldest_row;
    if (mem_rvalid) begin
      ld_wb_ix    <= row_rob_ix[out_row];
      ld_wb_value <= mem_rdata;
      // the row leaving is age 0, so every other row moves up one place
      for (int i = 0; i < ooo_cfg_pkg::LOAD_BUFFER_DEPTH; i++) begin
        if (occupied[i] && row_age[i] != '0) row_age[i] <= row_age[i] - 1'b1;
      end
    end
    if (ld_issue) begin
      row_addr[open_row]   <= ld_addr;
      row_rob_ix[open_row] <= ld_rob_ix;
      row_age[open_row]    <= occ_count - {1'b0, mem_rvalid}; // youngest
    end
  end

  a_no_issue_full: assert property (@(posedge clk_in) disable iff (rst_in)
    ld_issue |-> !(&occupied));

  // memory answers only what was asked, once
  a_rvalid_outstanding: assert property (@(posedge clk_in) disable iff (rst_in)
    mem_rvalid |-> out_valid);

endmodule

`default_nettype wire

// File: source/ooo_cfg_pkg.sv
`default_nettype none

package ooo_cfg_pkg;

  // architectural registers x0..x7
  localparam int NUM_REGS = 8;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_ix_t;

  // reorder buffer, index wraps on its own at a power of two
  localparam int ROB_DEPTH = 8;
  typedef logic [$clog2(ROB_DEPTH)-1:0] rob_ix_t;

  localparam int LOAD_BUFFER_DEPTH = 3; // pending loads waiting on the memory port
  typedef logic [$clog2(LOAD_BUFFER_DEPTH)-1:0] lb_ix_t;

endpackage

`default_nettype wire

// File: source/ooo_top.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_top (
  input  wire                             clk_in,
  input  wire                             rst_in,
  input  wire                             instr_valid,
  input  wire  [31:0]                     instr,
  output logic                            instr_ready,
  output logic                            mem_req,
  output logic [isa_pkg::XLEN-1:0]        mem_addr,
  input  wire                             mem_rvalid,
  input  wire  [isa_pkg::XLEN-1:0]        mem_rdata,
  output logic                            commit_valid,
  output ooo_cfg_pkg::reg_ix_t            commit_rd,
  output logic [isa_pkg::XLEN-1:0]        commit_value
);

  // decode to rob
  logic                     alloc_valid;
  ooo_cfg_pkg::reg_ix_t     alloc_rd;
  logic                     alloc_has_dest;
  ooo_cfg_pkg::rob_ix_t     alloc_ix;
  logic                     rob_full;
  // decode to alu
  logic                     alu_issue;
  isa_pkg::alu_func_t       alu_func;
  logic [isa_pkg::XLEN-1:0] alu_op_a;
  logic [isa_pkg::XLEN-1:0] alu_op_b;
  ooo_cfg_pkg::rob_ix_t     alu_rob_ix;
  // decode to load buffer
  logic                     ld_issue;
  logic [isa_pkg::XLEN-1:0] ld_addr;
  ooo_cfg_pkg::rob_ix_t     ld_rob_ix;
  logic                     lb_ready;
  // result write ports into the rob
  logic                     alu_wb_valid;
  ooo_cfg_pkg::rob_ix_t     alu_wb_ix;
  logic [isa_pkg::XLEN-1:0] alu_wb_value;
  logic                     ld_wb_valid;
  ooo_cfg_pkg::rob_ix_t     ld_wb_ix;
  logic [isa_pkg::XLEN-1:0] ld_wb_value;

  issue_decode decode_i (
    .clk_in(clk_in), .rst_in(rst_in),
    .instr_valid(instr_valid), .instr(instr), .instr_ready(instr_ready),
    .rob_full(rob_full), .lb_ready(lb_ready), .alloc_ix(alloc_ix),
    .alloc_valid(alloc_valid), .alloc_rd(alloc_rd), .alloc_has_dest(alloc_has_dest),
    .alu_issue(alu_issue), .alu_func(alu_func), .alu_op_a(alu_op_a),
    .alu_op_b(alu_op_b), .alu_rob_ix(alu_rob_ix),
    .ld_issue(ld_issue), .ld_addr(ld_addr), .ld_rob_ix(ld_rob_ix),
    .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value)
  );

  alu_exec alu_i (
    .clk_in(clk_in), .rst_in(rst_in),
    .alu_issue(alu_issue), .alu_func(alu_func), .alu_op_a(alu_op_a),
    .alu_op_b(alu_op_b), .alu_rob_ix(alu_rob_ix),
    .alu_wb_valid(alu_wb_valid), .alu_wb_ix(alu_wb_ix), .alu_wb_value(alu_wb_value)
  );

  load_buffer lb_i (
    .clk_in(clk_in), .rst_in(rst_in),
    .ld_issue(ld_issue), .ld_addr(ld_addr), .ld_rob_ix(ld_rob_ix), .lb_ready(lb_ready),
    .mem_req(mem_req), .mem_addr(mem_addr), .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata),
    .ld_wb_valid(ld_wb_valid), .ld_wb_ix(ld_wb_ix), .ld_wb_value(ld_wb_value)
  );

  // commit port goes straight out and back into decode
  reorder_buffer rob_i (
    .clk_in(clk_in), .rst_in(rst_in),
    .alloc_valid(alloc_valid), .alloc_rd(alloc_rd), .alloc_has_dest(alloc_has_dest),
    .alloc_ix(alloc_ix), .rob_full(rob_full),
    .alu_wb_valid(alu_wb_valid), .alu_wb_ix(alu_wb_ix), .alu_wb_value(alu_wb_value),
    .ld_wb_valid(ld_wb_valid), .ld_wb_ix(ld_wb_ix), .ld_wb_value(ld_wb_value),
    .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value)
  );

endmodule

`default_nettype wire

// File: source/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
  input  wire                             clk_in,
  input  wire                             rst_in,
  input  wire                             alloc_valid,
  input  wire  ooo_cfg_pkg::reg_ix_t      alloc_rd,
  input  wire                             alloc_has_dest,
  output ooo_cfg_pkg::rob_ix_t            alloc_ix,
  output logic                            rob_full,
  input  wire                             alu_wb_valid,
  input  wire  ooo_cfg_pkg::rob_ix_t      alu_wb_ix,
  input  wire  [isa_pkg::XLEN-1:0]        alu_wb_value,
  input  wire                             ld_wb_valid,
  input  wire  ooo_cfg_pkg::rob_ix_t      ld_wb_ix,
  input  wire  [isa_pkg::XLEN-1:0]        ld_wb_value,
  output logic                            commit_valid,
  output ooo_cfg_pkg::reg_ix_t            commit_rd,
  output logic [isa_pkg::XLEN-1:0]        commit_value
);

  logic [ooo_cfg_pkg::ROB_DEPTH-1:0] done; // result has been written
  logic [ooo_cfg_pkg::ROB_DEPTH-1:0] ent_has_dest;
  ooo_cfg_pkg::reg_ix_t ent_rd [ooo_cfg_pkg::ROB_DEPTH];
  logic [isa_pkg::XLEN-1:0] ent_value [ooo_cfg_pkg::ROB_DEPTH];
  ooo_cfg_pkg::rob_ix_t head; // oldest instruction
  ooo_cfg_pkg::rob_ix_t tail; // next free entry
  logic [$clog2(ooo_cfg_pkg::ROB_DEPTH):0] count;
  ooo_cfg_pkg::rob_ix_t alu_off;
  ooo_cfg_pkg::rob_ix_t ld_off;

  assign rob_full = count == ooo_cfg_pkg::ROB_DEPTH;
  assign alloc_ix = tail;

  // head retires as soon as its result is in, strictly in program order
  assign commit_valid = count != '0 && done[head];
  assign commit_rd    = ent_has_dest[head] ? ent_rd[head] : '0;
  assign commit_value = ent_value[head];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      done  <= '0;
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (alu_wb_valid) done[alu_wb_ix] <= 1'b1;
      if (ld_wb_valid)  done[ld_wb_ix]  <= 1'b1;
      if (commit_valid) begin
        done[head] <= 1'b0;
        head       <= head + 1'b1;
      end
      if (alloc_valid) begin
        done[tail] <= 1'b0;
        tail       <= tail + 1'b1;
      end
      case ({alloc_valid, commit_valid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (alloc_valid) begin
      ent_rd[tail]       <= alloc_rd;
      ent_has_dest[tail] <= alloc_has_dest;
    end
    if (alu_wb_valid) ent_value[alu_wb_ix] <= alu_wb_value;
    if (ld_wb_valid)  ent_value[ld_wb_ix]  <= ld_wb_value;
  end

  // distance from head, inside count means the entry is live
  assign alu_off = alu_wb_ix - head;
  assign ld_off  = ld_wb_ix - head;

  a_alu_wb_live: assert property (@(posedge clk_in) disable iff (rst_in)
    alu_wb_valid |-> ({1'b0, alu_off} < count));

  a_ld_wb_live: assert property (@(posedge clk_in) disable iff (rst_in)
    ld_wb_valid |-> ({1'b0, ld_off} < count));

  a_wb_distinct: assert property (@(posedge clk_in) disable iff (rst_in)
    !(alu_wb_valid && ld_wb_valid && alu_wb_ix == ld_wb_ix));

endmodule

`default_nettype wire

// File: sources.f
source/isa_pkg.sv
source/ooo_cfg_pkg.sv
source/issue_decode.sv
source/alu_exec.sv
source/load_buffer.sv
source/reorder_buffer.sv
source/ooo_top.sv
tb/ooo_tb.sv

// File: tb/ooo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_tb;

  localparam int INSTR_TOTAL = 238; // all tests together, random mix included
  localparam int CYCLE_LIMIT = 40 * INSTR_TOTAL; // 40 cycles per instruction sent

  logic clk_in;
  logic rst_in;
  logic instr_valid;
  logic [31:0] instr;
  logic instr_ready;
  logic mem_req;
  logic [isa_pkg::XLEN-1:0] mem_addr;
  logic mem_rvalid;
  logic [isa_pkg::XLEN-1:0] mem_rdata;
  logic commit_valid;
  ooo_cfg_pkg::reg_ix_t commit_rd;
  logic [isa_pkg::XLEN-1:0] commit_value;

  logic [31:0] rng_state = 32'h14a3;
  logic [31:0] delay_state = 32'h14a3; // memory delays draw from their own stream
  logic [31:0] model_regs [ooo_cfg_pkg::NUM_REGS]; // in-order architectural state
  ooo_cfg_pkg::reg_ix_t exp_rd [$];
  logic [31:0] exp_val [$];
  logic [31:0] ref_v;
  logic mem_hold; // memory stays silent while set
  logic mem_pending = 1'b0;
  logic [31:0] mem_paddr;
  int mem_wait;
  int errors = 0;
  int n_checks = 0;
  int n_sent = 0;
  int n_commits = 0;
  int cycles = 0;
  int n_tests = 0;
  int n_failed = 0;
  int err_base;
  string test_name;

  ooo_top dut_i (
    .clk_in(clk_in), .rst_in(rst_in),
    .instr_valid(instr_valid), .instr(instr), .instr_ready(instr_ready),
    .mem_req(mem_req), .mem_addr(mem_addr), .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata),
    .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value)
  );

  initial begin
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // memory content is a hash of the address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return ((addr >> 2) * 32'h9e3779b1) ^ addr;
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, isa_pkg::OPCODE_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, isa_pkg::OPCODE_OP_IMM};
  endfunction

  function automatic logic [31:0] lw_instr(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [4:0] rd);
    return {imm, rs1, isa_pkg::F3_LW, rd, isa_pkg::OPCODE_LOAD};
  endfunction

  // expected result of one instruction, from the rv32i rules
  function automatic logic [31:0] ref_value(input logic [31:0] w);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic alt;
    a   = model_regs[w[17:15]];
    imm = {{20{w[31]}}, w[31:20]};
    b   = (w[6:0] == isa_pkg::OPCODE_OP) ? model_regs[w[22:20]] : imm;
    alt = w[30];
    if (w[6:0] == isa_pkg::OPCODE_LOAD) return mem_word(a + imm);
    case (w[14:12])
      3'd0: return (w[6:0] == isa_pkg::OPCODE_OP && alt) ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // legal instructions only, registers x0..x7
  function automatic logic [31:0] random_instr();
    logic [31:0] r;
    logic [2:0] f3;
    logic [11:0] imm;
    logic [6:0] f7;
    r   = next_rand();
    f3  = r[13:11];
    imm = r[26:15];
    f7  = (r[14] && (f3 == 3'd0 || f3 == 3'd5)) ? isa_pkg::F7_ALT : isa_pkg::F7_BASE;
    case (r[1:0])
      2'd0: return r_type(f7, {2'b0, r[10:8]}, {2'b0, r[7:5]}, f3, {2'b0, r[4:2]});
      2'd2: return lw_instr(imm, {2'b0, r[7:5]}, {2'b0, r[4:2]});
      default: begin
        if (f3 == 3'd1) imm = {7'b0, imm[4:0]}; // slli
        if (f3 == 3'd5) imm = {r[14] ? isa_pkg::F7_ALT : isa_pkg::F7_BASE, imm[4:0]};
        return i_type(imm, {2'b0, r[7:5]}, f3, {2'b0, r[4:2]});
      end
    endcase
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // present one instruction and hold it until the DUT takes it
  task automatic send(input logic [31:0] word);
    instr_valid <= 1'b1;
    instr       <= word;
    @(posedge clk_in);
    while (!instr_ready) @(posedge clk_in);
    instr_valid <= 1'b0;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_base  = errors;
  endtask

  // returns once every accepted instruction has committed
  task automatic wait_drained();
    @(posedge clk_in); // push of the last accepted instruction lands here
    while (exp_rd.size() != 0) @(posedge clk_in);
  endtask

  task automatic report_test();
    wait_drained();
    n_tests++;
    if (errors != err_base) n_failed++;
    $display("test %0d %s: %s", n_tests, test_name, (errors == err_base) ? "ok" : "FAILED");
  endtask

  // reference model follows every accepted instruction in program order
  always @(posedge clk_in) begin
    if (!rst_in && instr_valid && instr_ready) begin
      ref_v = ref_value(instr);
      exp_rd.push_back(instr[9:7]);
      exp_val.push_back(ref_v);
      if (instr[9:7] != 3'd0) model_regs[instr[9:7]] = ref_v; // x0 stays zero
      n_sent++;
    end
  end

  always @(posedge clk_in) begin
    if (!rst_in && commit_valid) begin
      n_commits++;
      if (exp_rd.size() == 0) begin
        errors++;
        $display("a commit arrived at %0t with no instruction pending", $time);
      end else begin
        check("commit rd", 32'(commit_rd), 32'(exp_rd.pop_front()));
        check("commit value", commit_value, exp_val.pop_front());
      end
    end
  end

  // variable latency memory, one request at a time
  always @(posedge clk_in) begin
    mem_rvalid <= 1'b0;
    if (rst_in) mem_pending = 1'b0;
    else if (mem_req) begin
      mem_pending = 1'b1;
      mem_paddr   = mem_addr;
      delay_state = xorshift(delay_state);
      mem_wait    = 1 + int'(delay_state % 6);
    end else if (mem_pending && !mem_hold) begin
      if (mem_wait <= 1) begin
        mem_rvalid  <= 1'b1;
        mem_rdata   <= mem_word(mem_paddr);
        mem_pending = 1'b0;
      end else mem_wait--;
    end
  end

  always @(posedge clk_in) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: no progress within %0d cycles", CYCLE_LIMIT);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    rst_in      = 1'b1;
    instr_valid = 1'b0;
    instr       = 32'h0;
    mem_rvalid  = 1'b0;
    mem_rdata   = 32'h0;
    mem_hold    = 1'b0;
    for (int i = 0; i < ooo_cfg_pkg::NUM_REGS; i++) model_regs[i] = 32'h0;
    repeat (5) @(posedge clk_in);
    rst_in <= 1'b0;
    @(posedge clk_in);

    begin_test("dependent alu chain");
    send(i_type(12'h123, 0, isa_pkg::F3_ADD, 1));
    send(i_type(12'hffb, 0, isa_pkg::F3_ADD, 2)); // -5
    send(r_type(isa_pkg::F7_BASE, 2, 1, isa_pkg::F3_ADD, 3));
    send(r_type(isa_pkg::F7_ALT, 2, 3, isa_pkg::F3_ADD, 4)); // sub
    send(r_type(isa_pkg::F7_BASE, 2, 4, isa_pkg::F3_SLL, 5)); // shamt 27
    send(r_type(isa_pkg::F7_BASE, 1, 5, isa_pkg::F3_SR, 6));
    send(r_type(isa_pkg::F7_ALT, 1, 5, isa_pkg::F3_SR, 7)); // sra
    send(r_type(isa_pkg::F7_BASE, 6, 7, isa_pkg::F3_SLT, 1));
    send(r_type(isa_pkg::F7_BASE, 6, 7, isa_pkg::F3_SLTU, 2));
    send(r_type(isa_pkg::F7_BASE, 2, 7, isa_pkg::F3_XOR, 3));
    send(r_type(isa_pkg::F7_BASE, 5, 3, isa_pkg::F3_OR, 4));
    send(r_type(isa_pkg::F7_BASE, 3, 4, isa_pkg::F3_AND, 5));
    send(i_type(12'h004, 5, isa_pkg::F3_SLL, 6));
    send(i_type(12'h002, 6, isa_pkg::F3_SR, 7));
    send(i_type(12'h403, 7, isa_pkg::F3_SR, 1)); // srai by 3
    send(i_type(12'hfff, 1, isa_pkg::F3_SLT, 2));
    send(i_type(12'hfff, 1, isa_pkg::F3_SLTU, 3));
    send(i_type(12'h7ff, 3, isa_pkg::F3_XOR, 4));
    send(i_type(12'h100, 4, isa_pkg::F3_OR, 5));
    send(i_type(12'h0f0, 5, isa_pkg::F3_AND, 6));
    report_test();

    begin_test("load then independent alu");
    send(lw_instr(12'h010, 0, 1));
    send(i_type(12'h007, 0, isa_pkg::F3_ADD, 2));
    send(r_type(isa_pkg::F7_BASE, 7, 6, isa_pkg::F3_ADD, 3)); // finishes before the load
    send(i_type(12'h055, 0, isa_pkg::F3_XOR, 4));
    send(i_type(12'h003, 6, isa_pkg::F3_SLL, 5));
    report_test();

    begin_test("use of a loaded value");
    send(i_type(12'h040, 0, isa_pkg::F3_ADD, 5));
    send(lw_instr(12'h004, 5, 6));
    send(r_type(isa_pkg::F7_BASE, 5, 6, isa_pkg::F3_ADD, 7)); // waits on x6
    send(r_type(isa_pkg::F7_ALT, 6, 7, isa_pkg::F3_ADD, 1));
    report_test();

    begin_test("full load buffer");
    mem_hold <= 1'b1;
    send(lw_instr(12'h000, 0, 1));
    send(lw_instr(12'h004, 0, 2));
    send(lw_instr(12'h008, 0, 3));
    instr_valid <= 1'b1;
    instr       <= lw_instr(12'h00c, 0, 4);
    repeat (3) begin
      @(posedge clk_in);
      check("instr_ready for a fourth load", 32'(instr_ready), 32'd0);
    end
    instr <= i_type(12'h04d, 0, isa_pkg::F3_ADD, 5); // free registers, still taken
    @(posedge clk_in);
    check("instr_ready for an alu op", 32'(instr_ready), 32'd1);
    instr_valid <= 1'b0;
    mem_hold    <= 1'b0;
    send(lw_instr(12'h00c, 0, 4));
    report_test();

    begin_test("writes to x0");
    send(i_type(12'h063, 0, isa_pkg::F3_ADD, 0));
    send(lw_instr(12'h020, 0, 0));
    wait_drained(); // both x0 writes have committed
    send(r_type(isa_pkg::F7_BASE, 0, 0, isa_pkg::F3_ADD, 1)); // reads back zero
    send(i_type(12'h005, 0, isa_pkg::F3_OR, 2));
    report_test();

    begin_test("random mix");
    repeat (200) begin
      send(random_instr());
      if (next_rand() < 32'h2000_0000) @(posedge clk_in); // occasional bubble
    end
    wait_drained();
    repeat (20) @(posedge clk_in); // a stray late commit would show up here
    check("commit count", n_commits, n_sent);
    report_test();

    $display("%0d tests, %0d failed, %0d checks, %0d errors", n_tests, n_failed,
             n_checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
